// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int XLEN   = 64;
    localparam int STRB_W = XLEN / 8;
    localparam int OFFS_W = $clog2(STRB_W);

    typedef enum logic [3:0] {
        NOP = 4'd0,
        LB  = 4'd1,
        LH  = 4'd2,
        LW  = 4'd3,
        LD  = 4'd4,
        LBU = 4'd5,
        LHU = 4'd6,
        LWU = 4'd7,
        SB  = 4'd8,
        SH  = 4'd9,
        SW  = 4'd10,
        SD  = 4'd11
    } mem_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE   = 2'd0,
        SZ_HALF   = 2'd1,
        SZ_WORD   = 2'd2,
        SZ_DOUBLE = 2'd3
    } mem_size_e;

    typedef enum logic [1:0] {
        EXC_NONE           = 2'd0,
        EXC_LOAD_MISALIGN  = 2'd1,
        EXC_STORE_MISALIGN = 2'd2
    } mem_exc_e;

    function automatic logic is_load(mem_op_e op);
        return op inside {LB, LH, LW, LD, LBU, LHU, LWU};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

endpackage

`default_nettype wire

// File: mem_stage_if.sv
`default_nettype none

// One memory operation moving between two pipeline stages
interface mem_stage_if import mem_pkg::*; #(
    parameter int ADDR_W = 32
);
    logic              valid;
    logic              ready;
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    mem_size_e         size;
    mem_exc_e          exc;
    logic [XLEN-1:0]   data;   // Store data on lanes, or raw read word
    logic [STRB_W-1:0] strb;

    modport src (
        output valid, op, addr, size, exc, data, strb,
        input  ready
    );

    modport dst (
        input  valid, op, addr, size, exc, data, strb,
        output ready
    );

endinterface

`default_nettype wire

// File: mem_req_decode.sv
`default_nettype none

module mem_req_decode import mem_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    output logic              req_ready,
    input  mem_op_e           req_op,
    input  logic [ADDR_W-1:0] req_addr,
    input  logic [XLEN-1:0]   req_wdata,
    mem_stage_if.src          out
);

    logic [OFFS_W-1:0] offs;
    mem_size_e         size;
    logic              misaligned;
    logic [STRB_W-1:0] size_mask;
    mem_exc_e          exc;
    logic              store_ok;
    logic              take;

    assign offs      = req_addr[OFFS_W-1:0];
    assign req_ready = !out.valid || out.ready;   // Empty, or draining this cycle
    assign take      = req_valid && req_ready;

    always_comb begin
        case (req_op)
            LH, LHU, SH: size = SZ_HALF;
            LW, LWU, SW: size = SZ_WORD;
            LD, SD:      size = SZ_DOUBLE;
            default:     size = SZ_BYTE;
        endcase
    end

    // Natural alignment per access size
    always_comb begin
        case (size)
            SZ_HALF: begin
                misaligned = offs[0];
                size_mask  = 8'h03;
            end
            SZ_WORD: begin
                misaligned = |offs[1:0];
                size_mask  = 8'h0f;
            end
            SZ_DOUBLE: begin
                misaligned = |offs;
                size_mask  = 8'hff;
            end
            default: begin
                misaligned = 1'b0;
                size_mask  = 8'h01;
            end
        endcase
    end

    always_comb begin
        exc = EXC_NONE;
        if (misaligned && is_load(req_op)) begin
            exc = EXC_LOAD_MISALIGN;
        end else if (misaligned && is_store(req_op)) begin
            exc = EXC_STORE_MISALIGN;
        end
    end

    assign store_ok = is_store(req_op) && !misaligned;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (take) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out.op   <= req_op;
            out.addr <= req_addr;
            out.size <= size;
            out.exc  <= exc;
            // Move store bytes onto their lanes within the 64-bit word
            out.data <= store_ok ? (req_wdata << {offs, 3'b000}) : '0;
            out.strb <= store_ok ? (size_mask << offs) : '0;
        end
    end

    a_strb_store_only: assert property (@(posedge clk) disable iff (rst)
        out.valid && (out.strb != '0) |-> is_store(out.op) && (out.exc == EXC_NONE));

endmodule

`default_nettype wire

// File: mem_bus_master.sv
`default_nettype none

module mem_bus_master import mem_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    mem_stage_if.dst          in,
    mem_stage_if.src          out,
    output logic              bus_req_valid,
    input  logic              bus_req_ready,
    output logic              bus_req_write,
    output logic [ADDR_W-1:0] bus_req_addr,
    output mem_size_e         bus_req_size,
    output logic [XLEN-1:0]   bus_req_wdata,
    output logic [STRB_W-1:0] bus_req_strb,
    input  logic              bus_rsp_valid,
    input  logic [XLEN-1:0]   bus_rsp_rdata
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_DONE
    } state_e;

    state_e            state;
    mem_op_e           op_q;
    logic [ADDR_W-1:0] addr_q;
    mem_size_e         size_q;
    mem_exc_e          exc_q;
    logic [XLEN-1:0]   data_q;     // Write data first, then the read word
    logic [STRB_W-1:0] strb_q;
    logic              take;
    logic              no_access;

    // A finished item can be replaced in the same cycle it leaves
    assign in.ready  = (state == S_IDLE) || (state == S_DONE && out.ready);
    assign take      = in.valid && in.ready;
    assign no_access = (in.op == NOP) || (in.exc != EXC_NONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    if (take) begin
                        state <= no_access ? S_DONE : S_REQ;
                    end else if (state == S_DONE && out.ready) begin
                        state <= S_IDLE;
                    end
                end
                S_REQ: begin
                    if (bus_req_ready) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (bus_rsp_valid) begin
                        state <= S_DONE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q   <= in.op;
            addr_q <= in.addr;
            size_q <= in.size;
            exc_q  <= in.exc;
            data_q <= in.data;
            strb_q <= in.strb;
        end else if (state == S_WAIT && bus_rsp_valid) begin
            data_q <= bus_req_write ? '0 : bus_rsp_rdata;
        end
    end

    assign bus_req_valid = (state == S_REQ);
    assign bus_req_write = is_store(op_q);
    assign bus_req_addr  = addr_q;
    assign bus_req_size  = size_q;
    assign bus_req_wdata = data_q;
    assign bus_req_strb  = strb_q;

    assign out.valid = (state == S_DONE);
    assign out.op    = op_q;
    assign out.addr  = addr_q;
    assign out.size  = size_q;
    assign out.exc   = exc_q;
    assign out.data  = data_q;
    assign out.strb  = '0;

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        bus_req_valid && !bus_req_ready |=> bus_req_valid
            && $stable({bus_req_write, bus_req_addr, bus_req_size, bus_req_wdata, bus_req_strb}));

    // Memory side must not answer a request that was never sent
    a_rsp_expected: assert property (@(posedge clk) disable iff (rst)
        bus_rsp_valid |-> state == S_WAIT);

endmodule

`default_nettype wire

// File: mem_load_format.sv
`default_nettype none

module mem_load_format import mem_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic            clk,
    input  logic            rst,
    mem_stage_if.dst        in,
    output logic            rsp_valid,
    input  logic            rsp_ready,
    output logic [XLEN-1:0] rsp_data,
    output mem_exc_e        rsp_exc
);

    logic [ADDR_W-1:0] ld_addr;
    logic [XLEN-1:0]   shifted;
    logic [XLEN-1:0]   load_data;
    logic              take;

    assign in.ready = !rsp_valid || rsp_ready;
    assign take     = in.valid && in.ready;
    assign ld_addr  = in.addr;

    // Addressed byte moves down to lane 0
    assign shifted = in.data >> {ld_addr[OFFS_W-1:0], 3'b000};

    always_comb begin
        load_data = '0;
        if (in.exc == EXC_NONE) begin
            case (in.op)
                LB:  load_data = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
                LH:  load_data = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
                LW:  load_data = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
                LBU: load_data = {{(XLEN-8){1'b0}}, shifted[7:0]};
                LHU: load_data = {{(XLEN-16){1'b0}}, shifted[15:0]};
                LWU: load_data = {{(XLEN-32){1'b0}}, shifted[31:0]};
                LD:  load_data = shifted;
                default: load_data = '0;   // Stores and NOP
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (take) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rsp_data <= load_data;
            rsp_exc  <= in.exc;
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_exc));

endmodule

`default_nettype wire

// File: mem_unit.sv
`default_nettype none

module mem_unit import mem_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst,

    // Core request
    input  logic              req_valid,
    output logic              req_ready,
    input  mem_op_e           req_op,
    input  logic [ADDR_W-1:0] req_addr,
    input  logic [XLEN-1:0]   req_wdata,

    // Core response
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output logic [XLEN-1:0]   rsp_data,
    output mem_exc_e          rsp_exc,

    // Memory bus
    output logic              bus_req_valid,
    input  logic              bus_req_ready,
    output logic              bus_req_write,
    output logic [ADDR_W-1:0] bus_req_addr,
    output mem_size_e         bus_req_size,
    output logic [XLEN-1:0]   bus_req_wdata,
    output logic [STRB_W-1:0] bus_req_strb,
    input  logic              bus_rsp_valid,
    input  logic [XLEN-1:0]   bus_rsp_rdata
);

    mem_stage_if #(.ADDR_W(ADDR_W)) dec2bus ();
    mem_stage_if #(.ADDR_W(ADDR_W)) bus2fmt ();

    mem_req_decode #(
        .ADDR_W (ADDR_W)
    ) u_dec (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .out       (dec2bus.src)
    );

    mem_bus_master #(
        .ADDR_W (ADDR_W)
    ) u_bus (
        .clk           (clk),
        .rst           (rst),
        .in            (dec2bus.dst),
        .out           (bus2fmt.src),
        .bus_req_valid (bus_req_valid),
        .bus_req_ready (bus_req_ready),
        .bus_req_write (bus_req_write),
        .bus_req_addr  (bus_req_addr),
        .bus_req_size  (bus_req_size),
        .bus_req_wdata (bus_req_wdata),
        .bus_req_strb  (bus_req_strb),
        .bus_rsp_valid (bus_rsp_valid),
        .bus_rsp_rdata (bus_rsp_rdata)
    );

    mem_load_format #(
        .ADDR_W (ADDR_W)
    ) u_fmt (
        .clk       (clk),
        .rst       (rst),
        .in        (bus2fmt.dst),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rsp_exc   (rsp_exc)
    );

endmodule

`default_nettype wire

// File: tb_bus_mem.sv
`default_nettype none

module tb_bus_mem import mem_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    output logic              req_ready,
    input  logic              req_write,
    input  logic [ADDR_W-1:0] req_addr,
    input  logic [XLEN-1:0]   req_wdata,
    input  logic [STRB_W-1:0] req_strb,
    output logic              rsp_valid,
    output logic [XLEN-1:0]   rsp_rdata
);

    logic [XLEN-1:0] mem [0:63];   // Indexed by address bits 8..3
    logic            busy;
    logic [1:0]      delay;
    integer          seed;
    int              i;
    int              b;

    function automatic logic [7:0] fill_byte(int a);
        return 8'((a * 7) + (a >> 5) + 8'h31);
    endfunction

    initial begin
        seed = 42622;
        for (i = 0; i < 512; i++) begin
            mem[i / 8][8*(i % 8) +: 8] = fill_byte(i);
        end
    end

    assign rsp_valid = busy && (delay == 2'd0);

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            req_ready <= 1'b0;
            busy      <= 1'b0;
            delay     <= 2'd0;
        end else if (!busy) begin
            if (req_valid && req_ready) begin
                rsp_rdata <= mem[req_addr[8:3]];
                if (req_write) begin
                    for (b = 0; b < STRB_W; b++) begin
                        if (req_strb[b]) begin
                            mem[req_addr[8:3]][8*b +: 8] = req_wdata[8*b +: 8];
                        end
                    end
                end
                busy      <= 1'b1;
                delay     <= 2'($random(seed));   // 0 to 3 cycles
                req_ready <= 1'b0;
            end else begin
                req_ready <= ($random(seed) % 4) != 0;
            end
        end else if (delay == 2'd0) begin
            busy      <= 1'b0;
            req_ready <= ($random(seed) % 4) != 0;
        end else begin
            delay <= delay - 2'd1;
        end
    end

endmodule

`default_nettype wire

// File: tb_mem_unit.sv
`default_nettype none

module tb_mem_unit import mem_pkg::*; ();

    localparam int ADDR_W = 32;

    logic              clk;
    logic              rst;
    logic              req_valid;
    logic              req_ready;
    mem_op_e           req_op;
    logic [ADDR_W-1:0] req_addr;
    logic [XLEN-1:0]   req_wdata;
    logic              rsp_valid;
    logic              rsp_ready;
    logic [XLEN-1:0]   rsp_data;
    mem_exc_e          rsp_exc;
    logic              bus_req_valid;
    logic              bus_req_ready;
    logic              bus_req_write;
    logic [ADDR_W-1:0] bus_req_addr;
    mem_size_e         bus_req_size;
    logic [XLEN-1:0]   bus_req_wdata;
    logic [STRB_W-1:0] bus_req_strb;
    logic              bus_rsp_valid;
    logic [XLEN-1:0]   bus_rsp_rdata;

    string             t_name[$];
    mem_op_e           t_op[$];
    logic [ADDR_W-1:0] t_addr[$];
    logic [XLEN-1:0]   t_wdata[$];
    logic [XLEN-1:0]   t_data[$];
    mem_exc_e          t_exc[$];
    string             bus_name[$];      // Entries that reach the bus, in order
    mem_size_e         bus_size[$];
    int                n_bus;
    logic [7:0]        shadow [0:511];   // Byte image of the bus memory
    int                n_tests;
    logic              table_ready;
    integer            seed;

    mem_unit #(.ADDR_W(ADDR_W)) uut (.*);

    tb_bus_mem #(.ADDR_W(ADDR_W)) mem_model (
        .clk       (clk),
        .rst       (rst),
        .req_valid (bus_req_valid),
        .req_ready (bus_req_ready),
        .req_write (bus_req_write),
        .req_addr  (bus_req_addr),
        .req_wdata (bus_req_wdata),
        .req_strb  (bus_req_strb),
        .rsp_valid (bus_rsp_valid),
        .rsp_rdata (bus_rsp_rdata)
    );

    function automatic logic [7:0] fill_byte(int a);
        return 8'((a * 7) + (a >> 5) + 8'h31);
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_data(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s data: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_exc(string name, mem_exc_e exp, mem_exc_e act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s exc: expected %s, actual %s", name, exp.name(),
                act.name()));
        end
    endtask

    task automatic check_size(string name, mem_size_e exp, mem_size_e act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s bus size: expected %s, actual %s", name, exp.name(),
                act.name()));
        end
    endtask

    // Expected result from alignment, lane and extension rules on the byte image
    task automatic add_entry(mem_op_e op, int addr, logic [XLEN-1:0] wdata);
        int              nbytes;
        int              k;
        logic [XLEN-1:0] value;
        mem_exc_e        exc;
        mem_size_e       size;
        string           name;
        name  = $sformatf("%0d_%s_%0h", t_name.size(), op.name(), addr);
        value = '0;
        exc   = EXC_NONE;
        case (op)
            LB, LBU, SB: nbytes = 1;
            LH, LHU, SH: nbytes = 2;
            LW, LWU, SW: nbytes = 4;
            LD, SD:      nbytes = 8;
            default:     nbytes = 0;
        endcase
        case (nbytes)
            2:       size = SZ_HALF;
            4:       size = SZ_WORD;
            8:       size = SZ_DOUBLE;
            default: size = SZ_BYTE;
        endcase
        if (nbytes > 1 && (addr % nbytes) != 0) begin
            exc = (op inside {SH, SW, SD}) ? EXC_STORE_MISALIGN : EXC_LOAD_MISALIGN;
        end else if (op inside {SB, SH, SW, SD}) begin
            for (k = 0; k < nbytes; k++) begin
                shadow[(addr + k) % 512] = wdata[8*k +: 8];
            end
        end else if (nbytes > 0) begin
            for (k = 0; k < nbytes; k++) begin
                value[8*k +: 8] = shadow[(addr + k) % 512];
            end
            if (op inside {LB, LH, LW} && value[8*nbytes-1]) begin
                for (k = nbytes; k < 8; k++) begin
                    value[8*k +: 8] = 8'hff;
                end
            end
        end
        if (nbytes > 0 && exc == EXC_NONE) begin
            bus_name.push_back(name);
            bus_size.push_back(size);
        end
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_wdata.push_back(wdata);
        t_data.push_back(value);
        t_exc.push_back(exc);
    endtask

    task automatic build_table();
        int k;
        for (k = 0; k < 512; k++) begin
            shadow[k] = fill_byte(k);
        end
        add_entry(SD, 'h100, 64'h0123_4567_89ab_cdef);
        add_entry(LD, 'h100, '0);
        for (k = 0; k < 8; k++) begin
            add_entry(SB, 'h108 + k, 64'h5a5a_5a5a_5a5a_5a90 + k);
            add_entry(LD, 'h108, '0);
        end
        for (k = 0; k < 8; k += 2) begin
            add_entry(SH, 'h110 + k, 64'h3c3c_3c3c_3c3c_c3a0 + k);
            add_entry(LD, 'h110, '0);
        end
        for (k = 0; k < 8; k += 4) begin
            add_entry(SW, 'h118 + k, 64'h7777_7777_f1e2_d3c0 + k);
            add_entry(LD, 'h118, '0);
        end
        add_entry(SD, 'h140, 64'hf08c_7e55_8123_4a96);   // Mixed sign bits per byte
        for (k = 0; k < 8; k++) begin
            add_entry(LB, 'h140 + k, '0);
            add_entry(LBU, 'h140 + k, '0);
        end
        for (k = 0; k < 8; k += 2) begin
            add_entry(LH, 'h140 + k, '0);
            add_entry(LHU, 'h140 + k, '0);
        end
        for (k = 0; k < 8; k += 4) begin
            add_entry(LW, 'h140 + k, '0);
            add_entry(LWU, 'h140 + k, '0);
        end
        add_entry(LD, 'h1f8, '0);
        add_entry(LH, 'h141, '0);
        add_entry(LHU, 'h143, '0);
        add_entry(LW, 'h142, '0);
        add_entry(LWU, 'h146, '0);
        add_entry(LD, 'h144, '0);
        add_entry(SH, 'h149, '1);
        add_entry(SW, 'h14a, '1);
        add_entry(SD, 'h14c, '1);
        add_entry(LD, 'h148, '0);   // Still the fill pattern
        add_entry(NOP, 'h0, '1);
    endtask

    task automatic send_requests();
        int i;
        for (i = 0; i < n_tests; i++) begin
            @(negedge clk);
            req_valid = 1'b1;
            req_op    = t_op[i];
            req_addr  = t_addr[i];
            req_wdata = t_wdata[i];
            @(posedge clk);
            while (!req_ready) begin
                @(posedge clk);
            end
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic collect_responses();
        int   j;
        logic done;
        for (j = 0; j < n_tests; j++) begin
            done = 1'b0;
            while (!done) begin
                @(negedge clk);
                rsp_ready = ($random(seed) % 3) != 0;
                @(posedge clk);
                if (rsp_valid && rsp_ready) begin
                    check_data(t_name[j], t_data[j], rsp_data);
                    check_exc(t_name[j], t_exc[j], rsp_exc);
                    done = 1'b1;
                end
            end
        end
    endtask

    // Bus request fields only change at the rising edge
    always @(negedge clk) begin
        if (bus_req_valid && bus_req_ready) begin
            if (n_bus >= bus_size.size()) begin
                fail_run("The unit issued a bus request that no table entry needs");
            end else begin
                check_size(bus_name[n_bus], bus_size[n_bus], bus_req_size);
            end
            n_bus++;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        wait (table_ready);
        repeat (n_tests * 100) @(posedge clk);
        fail_run("Timeout: the unit stopped answering before the whole table completed");
    end

    initial begin
        int extra;
        extra       = 0;
        n_bus       = 0;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_op      = NOP;
        req_addr    = '0;
        req_wdata   = '0;
        rsp_ready   = 1'b0;
        table_ready = 1'b0;
        seed        = 42622;
        build_table();
        n_tests     = t_name.size();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fork
            send_requests();
            collect_responses();
        join
        @(negedge clk);
        rsp_ready = 1'b1;
        repeat (20) begin
            @(posedge clk);
            if (rsp_valid) begin
                extra++;
            end
        end
        if (extra != 0) begin
            fail_run("The unit returned more responses than requests were sent");
        end else if (n_bus != bus_size.size()) begin
            fail_run("The unit skipped bus requests that the table needs");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: mem_unit.f
mem_pkg.sv
mem_stage_if.sv
mem_req_decode.sv
mem_bus_master.sv
mem_load_format.sv
mem_unit.sv
tb_bus_mem.sv
tb_mem_unit.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mem_unit \
    -f mem_unit.f -o sim_mem_unit
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_mem_unit)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
